// ==== alu_pipe_cfg.svh ====
`ifndef ALU_PIPE_CFG_SVH
`define ALU_PIPE_CFG_SVH

//////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////

// Operand and result width, one machine word
`define PIPE_WIDTH 32

// Architectural registers, r0 reads as zero
`define PIPE_NREGS 32

// Bits needed to name one register
`define PIPE_RIDX_W 5

`endif

// ==== alu_pipe_pkg.sv ====
`default_nettype none

`include "alu_pipe_cfg.svh"

package alu_pipe_pkg;

	// Basic datapath types
	typedef logic [`PIPE_WIDTH-1:0] word_t;
	typedef logic [`PIPE_RIDX_W-1:0] reg_idx_t;

	// Operand source, encoded as in the OpenRISC operand muxes
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} opsel_t;

	// ALU operation carried from decode into EX
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_NOP = 3'd7
	} alu_op_t;

	//////////////////////////////////////////////////
	// Instruction word, two views of the same 32 bits
	//////////////////////////////////////////////////

	// Register format
	typedef struct packed {
		logic [5:0]  opcode;
		reg_idx_t    rd;
		reg_idx_t    ra;
		reg_idx_t    rb;
		logic [10:0] func;
	} instr_reg_t;

	// Immediate format
	typedef struct packed {
		logic [5:0]         opcode;
		reg_idx_t           rd;
		reg_idx_t           ra;
		logic signed [15:0] imm;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_t;

	// Opcodes
	localparam logic [5:0] OPC_ALU  = 6'h38;
	localparam logic [5:0] OPC_ADDI = 6'h27;

	// Function field of OPC_ALU
	localparam logic [10:0] FN_ADD = 11'd0;
	localparam logic [10:0] FN_SUB = 11'd1;
	localparam logic [10:0] FN_AND = 11'd2;
	localparam logic [10:0] FN_OR  = 11'd3;
	localparam logic [10:0] FN_XOR = 11'd4;

endpackage

`default_nettype wire

// ==== alu_pipe_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_pipe_cfg.svh"

module alu_pipe_tb import alu_pipe_pkg::*; ();

	// Edges to wait for one accept and for the pipe to drain
	localparam int STEP_LIMIT = 100;
	localparam int DRAIN_LIMIT = 400;

	logic     clk = 1'b0;
	logic     reset = 1'b1;
	instr_t   instr = '0;
	logic     instr_valid = 1'b0;
	logic     ex_stall = 1'b0;
	logic     wb_valid;
	reg_idx_t wb_rd;
	word_t    wb_data;

	int       seed = 32'h97d9;
	int       n_checked = 0;
	word_t    model_rf [`PIPE_NREGS];
	// Expected writebacks in issue order
	reg_idx_t exp_rd_q [$];
	word_t    exp_data_q [$];

	alu_pipe_top UUT (
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instr_valid (instr_valid),
		.ex_stall    (ex_stall),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Error reporting and typed compares
	//////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_rd(input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t ns: writeback went to r%0d, expected r%0d",
				$time, got, exp));
		end
	endtask

	task automatic check_data(input word_t got, input word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t ns: writeback data %h, expected %h",
				$time, got, exp));
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Result of one instruction from the model registers
	function automatic word_t ref_result(input instr_t i);
		word_t a;
		word_t b;
		word_t res;
		int    imm_val;
		a = model_rf[i.r.ra];
		b = model_rf[i.r.rb];
		res = '0;
		if (i.r.opcode == OPC_ADDI) begin
			imm_val = $signed(i.i.imm);
			res = a + word_t'(imm_val);
		end else if (i.r.opcode == OPC_ALU) begin
			case (i.r.func)
				11'd0: res = a + b;
				11'd1: res = a - b;
				11'd2: res = a & b;
				11'd3: res = a | b;
				11'd4: res = a ^ b;
				default: res = '0;
			endcase
		end
		return res;
	endfunction

	// Only real operations to r1..r31 reach writeback
	function automatic logic ref_writes(input instr_t i);
		logic is_op;
		is_op = (i.r.opcode == OPC_ADDI) || (i.r.opcode == OPC_ALU && i.r.func <= 11'd4);
		return is_op && (i.r.rd != '0);
	endfunction

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic instr_t make_rr(input logic [10:0] fn, input reg_idx_t rd,
			input reg_idx_t ra, input reg_idx_t rb);
		instr_t i;
		i.r.opcode = OPC_ALU;
		i.r.rd = rd;
		i.r.ra = ra;
		i.r.rb = rb;
		i.r.func = fn;
		return i;
	endfunction

	function automatic instr_t make_addi(input reg_idx_t rd, input reg_idx_t ra,
			input logic [15:0] imm);
		instr_t i;
		i.i.opcode = OPC_ADDI;
		i.i.rd = rd;
		i.i.ra = ra;
		i.i.imm = imm;
		return i;
	endfunction

	// True with a chance of pct percent
	function automatic logic roll(input int pct);
		return ($unsigned($random(seed)) % 32'd100) < $unsigned(pct);
	endfunction

	function automatic instr_t random_instr();
		instr_t i;
		logic [31:0] r;
		logic [31:0] r2;
		r = $random(seed);
		r2 = $random(seed);
		// Registers r0..r7 only so that dependences come often
		i.r.opcode = OPC_ALU;
		i.r.rd = {2'b00, r[2:0]};
		i.r.ra = {2'b00, r[5:3]};
		i.r.rb = {2'b00, r[8:6]};
		i.r.func = {8'd0, r[11:9]};
		if (r[11:9] == 3'd5 || r[11:9] == 3'd6) begin
			i.i.opcode = OPC_ADDI;
			i.i.imm = r2[15:0];
		end
		return i;
	endfunction

	// Bubbles first and then hold the instruction until accepted
	task automatic send_instr(input instr_t i, input int max_gap, input int stall_pct);
		int gap;
		int waited;
		logic accepted;
		gap = 0;
		if (max_gap > 0) begin
			gap = int'($unsigned($random(seed)) % $unsigned(max_gap + 1));
		end
		for (int k = 0; k < gap; k++) begin
			instr_valid <= 1'b0;
			ex_stall <= roll(stall_pct);
			@(posedge clk);
		end
		if (ref_writes(i)) begin
			exp_rd_q.push_back(i.r.rd);
			exp_data_q.push_back(ref_result(i));
			model_rf[i.r.rd] = ref_result(i);
		end
		instr <= i;
		instr_valid <= 1'b1;
		ex_stall <= roll(stall_pct);
		waited = 0;
		accepted = 1'b0;
		while (!accepted && waited < STEP_LIMIT) begin
			@(posedge clk);
			if (instr_valid && !ex_stall) begin
				accepted = 1'b1;
			end else begin
				ex_stall <= roll(stall_pct);
				waited++;
			end
		end
		if (!accepted) begin
			abort_run("Instruction was never accepted, ex_stall stayed high");
		end
	endtask

	task automatic issue(input instr_t i);
		send_instr(i, 0, 0);
	endtask

	task automatic wait_drain();
		int waited;
		instr_valid <= 1'b0;
		ex_stall <= 1'b0;
		waited = 0;
		while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_rd_q.size() != 0) begin
			abort_run("Timeout: an expected writeback never came out of the pipeline");
		end
	endtask

	// One pop from the expected queues per writeback
	always @(posedge clk) begin
		if (!reset && wb_valid) begin
			if (exp_rd_q.size() == 0) begin
				abort_run($sformatf("Fail at %0t ns: writeback to r%0d with none expected",
					$time, wb_rd));
			end else begin
				check_rd(wb_rd, exp_rd_q.pop_front());
				check_data(wb_data, exp_data_q.pop_front());
				n_checked++;
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		for (int k = 0; k < `PIPE_NREGS; k++) begin
			model_rf[k] = '0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Any writeback from the idle pipe is an error
		repeat (20) @(posedge clk);

		// Dependent chain through the EX forward over all five functions
		issue(make_addi(5'd1, 5'd0, 16'd100));
		issue(make_addi(5'd2, 5'd0, 16'h1234));
		issue(make_rr(FN_ADD, 5'd3, 5'd1, 5'd2));
		issue(make_rr(FN_SUB, 5'd3, 5'd3, 5'd1));
		issue(make_rr(FN_AND, 5'd3, 5'd3, 5'd1));
		issue(make_rr(FN_OR, 5'd3, 5'd3, 5'd1));
		issue(make_rr(FN_XOR, 5'd3, 5'd3, 5'd2));
		wait_drain();

		// Distance two uses the WB forward and distance three the register file
		issue(make_addi(5'd4, 5'd0, 16'd7));
		issue(make_addi(5'd9, 5'd0, 16'd1));
		issue(make_rr(FN_ADD, 5'd5, 5'd4, 5'd4));
		issue(make_addi(5'd6, 5'd0, 16'd3));
		issue(make_addi(5'd9, 5'd9, 16'd1));
		issue(make_addi(5'd9, 5'd9, 16'd1));
		issue(make_rr(FN_SUB, 5'd7, 5'd6, 5'd5));
		wait_drain();

		// Immediates at both ends of the signed range
		issue(make_addi(5'd8, 5'd0, -16'sd5));
		issue(make_addi(5'd8, 5'd8, 16'h7fff));
		issue(make_addi(5'd10, 5'd8, 16'h8000));
		issue(make_rr(FN_ADD, 5'd11, 5'd10, 5'd8));
		wait_drain();

		// r0 as target is dropped and still reads zero
		issue(make_addi(5'd0, 5'd0, 16'd55));
		issue(make_rr(FN_ADD, 5'd0, 5'd1, 5'd2));
		issue(make_rr(FN_OR, 5'd12, 5'd0, 5'd0));
		issue(make_addi(5'd13, 5'd0, -16'sd1));
		issue(make_rr(FN_XOR, 5'd14, 5'd0, 5'd13));
		// Unknown function and unknown opcode behave as no-ops
		issue(make_rr(11'd7, 5'd15, 5'd1, 5'd2));
		issue({6'h05, 26'h3ffffff});
		wait_drain();

		// Random dependent stream with bubbles and back-pressure
		for (int n = 0; n < 300; n++) begin
			send_instr(random_instr(), 2, 30);
		end
		wait_drain();

		// Trailing edges let a stray writeback show up
		repeat (10) @(posedge clk);
		$display("%0d writebacks checked", n_checked);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== alu_pipe_top.f ====
+incdir+.
alu_pipe_pkg.sv
decode_stage.sv
operand_muxes.sv
execute_stage.sv
alu_pipe_top.sv
alu_pipe_tb.sv

// ==== alu_pipe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_pipe_cfg.svh"

module alu_pipe_top import alu_pipe_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  instr_t   instr,
	input  logic     instr_valid,
	input  logic     ex_stall,
	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output word_t    wb_data
);

	// Decode to operand stage
	logic     id_freeze;
	word_t    rf_data_a;
	word_t    rf_data_b;
	word_t    simm;
	opsel_t   sel_a;
	opsel_t   sel_b;

	// Decode to execute stage
	alu_op_t  id_op;
	reg_idx_t id_rd;
	logic     id_valid;

	// Operands and forwarding paths
	word_t    operand_a;
	word_t    operand_b;
	word_t    ex_forw;
	word_t    wb_forw;
	reg_idx_t ex_rd;
	logic     ex_valid;

	//////////////////////////////////////////////////
	// ID stage, register file written from WB
	//////////////////////////////////////////////////

	decode_stage u_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.ex_stall    (ex_stall),
		.instr       (instr),
		.wr_en       (wb_valid),
		.wr_idx      (wb_rd),
		.wr_data     (wb_forw),
		.ex_rd       (ex_rd),
		.wb_rd       (wb_rd),
		.ex_valid    (ex_valid),
		.wb_valid    (wb_valid),
		.id_freeze   (id_freeze),
		.rf_data_a   (rf_data_a),
		.rf_data_b   (rf_data_b),
		.simm        (simm),
		.sel_a       (sel_a),
		.sel_b       (sel_b),
		.id_op       (id_op),
		.id_rd       (id_rd),
		.id_valid    (id_valid)
	);

	// Operand stage, EX freeze is the stall input itself
	operand_muxes u_operands (
		.clk       (clk),
		.reset     (reset),
		.id_freeze (id_freeze),
		.ex_freeze (ex_stall),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_forw),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	execute_stage u_execute (
		.clk       (clk),
		.reset     (reset),
		.ex_freeze (ex_stall),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.id_op     (id_op),
		.id_rd     (id_rd),
		.id_valid  (id_valid),
		.id_freeze (id_freeze),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_forw),
		.ex_rd     (ex_rd),
		.ex_valid  (ex_valid),
		.wb_rd     (wb_rd),
		.wb_valid  (wb_valid)
	);

	// Write data is the writeback register
	assign wb_data = wb_forw;

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_pipe_cfg.svh"

module decode_stage import alu_pipe_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     instr_valid,
	input  logic     ex_stall,
	input  instr_t   instr,
	// Writeback port of the register file
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data,
	// Destinations further down the pipe
	input  reg_idx_t ex_rd,
	input  reg_idx_t wb_rd,
	input  logic     ex_valid,
	input  logic     wb_valid,
	output logic     id_freeze,
	output word_t    rf_data_a,
	output word_t    rf_data_b,
	output word_t    simm,
	output opsel_t   sel_a,
	output opsel_t   sel_b,
	output alu_op_t  id_op,
	output reg_idx_t id_rd,
	output logic     id_valid
);

	instr_t ir;
	logic   ir_valid;
	logic   use_imm;
	word_t  rf [`PIPE_NREGS];

	//////////////////////////////////////////////////
	// Instruction register
	//////////////////////////////////////////////////

	// Advances on every edge without back-pressure
	always_ff @(posedge clk) begin
		if (reset) begin
			ir_valid <= 1'b0;
		end else if (!ex_stall) begin
			ir_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_stall) begin
			ir <= instr;
		end
	end

	// A bubble in ID freezes the stage just like a stall
	assign id_freeze = ex_stall | ~ir_valid;
	assign id_valid = ir_valid;
	assign id_rd = ir.r.rd;

	//////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < `PIPE_NREGS; k++) begin
				rf[k] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			// r0 is never written
			rf[wr_idx] <= wr_data;
		end
	end

	assign rf_data_a = rf[ir.r.ra];
	assign rf_data_b = rf[ir.r.rb];

	// Sign extended 16-bit immediate
	assign simm = {{(`PIPE_WIDTH-16){ir.i.imm[15]}}, ir.i.imm};

	// Youngest producer wins and r0 is never forwarded
	function automatic opsel_t pick_src(input reg_idx_t src);
		opsel_t sel;
		sel = SEL_RF;
		if (src != '0) begin
			if (ex_valid && ex_rd == src) begin
				sel = SEL_EX_FORW;
			end else if (wb_valid && wb_rd == src) begin
				sel = SEL_WB_FORW;
			end
		end
		return sel;
	endfunction

	// Opcode decode
	always_comb begin
		id_op = ALU_NOP;
		use_imm = 1'b0;
		case (ir.r.opcode)
			OPC_ALU: begin
				case (ir.r.func)
					FN_ADD: id_op = ALU_ADD;
					FN_SUB: id_op = ALU_SUB;
					FN_AND: id_op = ALU_AND;
					FN_OR:  id_op = ALU_OR;
					FN_XOR: id_op = ALU_XOR;
					default: id_op = ALU_NOP;
				endcase
			end
			OPC_ADDI: begin
				id_op = ALU_ADD;
				use_imm = 1'b1;
			end
			default: id_op = ALU_NOP;
		endcase
	end

	// Operand source select from the hazard compare
	always_comb begin
		sel_a = pick_src(ir.r.ra);
		sel_b = use_imm ? SEL_IMM : pick_src(ir.r.rb);
	end

	// Source r0 must come from the register file or the immediate
	assert property (@(posedge clk) disable iff (reset)
		(ir_valid && ir.r.ra == '0) |-> sel_a == SEL_RF);
	assert property (@(posedge clk) disable iff (reset)
		(ir_valid && !use_imm && ir.r.rb == '0) |-> sel_b == SEL_RF);

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_pipe_cfg.svh"

module execute_stage import alu_pipe_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     ex_freeze,
	input  word_t    operand_a,
	input  word_t    operand_b,
	input  alu_op_t  id_op,
	input  reg_idx_t id_rd,
	input  logic     id_valid,
	input  logic     id_freeze,
	output word_t    ex_forw,
	output word_t    wb_forw,
	output reg_idx_t ex_rd,
	output logic     ex_valid,
	output reg_idx_t wb_rd,
	output logic     wb_valid
);

	alu_op_t  ex_op;
	reg_idx_t ex_rd_q;
	logic     ex_valid_q;
	logic     saved;
	logic     ex_writes;
	word_t    alu_res;
	word_t    wb_data_q;
	logic     wb_valid_q;

	//////////////////////////////////////////////////
	// EX control, same freeze rule as the operands
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_op <= ALU_NOP;
			ex_rd_q <= '0;
			ex_valid_q <= 1'b0;
			saved <= 1'b0;
		end else if (!ex_freeze) begin
			if (!id_freeze || !saved) begin
				ex_op <= id_op;
				ex_rd_q <= id_rd;
				ex_valid_q <= id_valid;
			end
			// set after the single capture, cleared once ID opens
			saved <= id_freeze;
		end
	end

	// Only real writes count, NOP and r0 are dropped
	assign ex_writes = ex_valid_q && ex_op != ALU_NOP && ex_rd_q != '0;

	// ALU
	always_comb begin
		case (ex_op)
			ALU_ADD: alu_res = operand_a + operand_b;
			ALU_SUB: alu_res = operand_a - operand_b;
			ALU_AND: alu_res = operand_a & operand_b;
			ALU_OR:  alu_res = operand_a | operand_b;
			ALU_XOR: alu_res = operand_a ^ operand_b;
			default: alu_res = '0;
		endcase
	end

	assign ex_forw = alu_res;
	assign ex_rd = ex_rd_q;
	assign ex_valid = ex_writes;

	//////////////////////////////////////////////////
	// Writeback register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid_q <= 1'b0;
		end else if (!ex_freeze) begin
			wb_valid_q <= ex_writes;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_data_q <= alu_res;
			wb_rd <= ex_rd_q;
		end
	end

	// Held data keeps the WB forward alive through a stall
	assign wb_forw = wb_data_q;
	assign wb_valid = wb_valid_q & ~ex_freeze;

	// No register file write under back-pressure
	assert property (@(posedge clk) disable iff (reset) ex_freeze |-> !wb_valid);

	// r0 never reaches the write port
	assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_rd != '0);

endmodule

`default_nettype wire

// ==== operand_muxes.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_pipe_cfg.svh"

module operand_muxes import alu_pipe_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   id_freeze,
	input  logic   ex_freeze,
	input  word_t  rf_data_a,
	input  word_t  rf_data_b,
	input  word_t  ex_forw,
	input  word_t  wb_forw,
	input  word_t  simm,
	input  opsel_t sel_a,
	input  opsel_t sel_b,
	output word_t  operand_a,
	output word_t  operand_b
);

	// Index 0 is operand a, index 1 is operand b
	word_t      muxed [2];
	word_t      op_q [2];
	logic [1:0] saved;

	//////////////////////////////////////////////////
	// Forwarding muxes
	//////////////////////////////////////////////////

	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed[0] = ex_forw;
			SEL_WB_FORW: muxed[0] = wb_forw;
			default:     muxed[0] = rf_data_a;
		endcase
	end

	// Operand b may also take the immediate
	always_comb begin
		case (sel_b)
			SEL_IMM:     muxed[1] = simm;
			SEL_EX_FORW: muxed[1] = ex_forw;
			SEL_WB_FORW: muxed[1] = wb_forw;
			default:     muxed[1] = rf_data_b;
		endcase
	end

	//////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////

	// Open stage captures every edge
	// With only ID frozen capture once and then hold
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < 2; k++) begin
				op_q[k] <= {`PIPE_WIDTH{1'b0}};
				saved[k] <= 1'b0;
			end
		end else if (!ex_freeze) begin
			for (int k = 0; k < 2; k++) begin
				if (!id_freeze) begin
					op_q[k] <= muxed[k];
					saved[k] <= 1'b0;
				end else if (!saved[k]) begin
					op_q[k] <= muxed[k];
					saved[k] <= 1'b1;
				end
			end
		end
	end

	assign operand_a = op_q[0];
	assign operand_b = op_q[1];

	// EX freeze holds both operands for the ALU
	assert property (@(posedge clk) disable iff (reset)
		ex_freeze |=> ($stable(operand_a) && $stable(operand_b)));

	// Selected source is what EX sees one edge later
	assert property (@(posedge clk) disable iff (reset)
		(!ex_freeze && !id_freeze && sel_a == SEL_EX_FORW) |=> operand_a == $past(ex_forw));
	assert property (@(posedge clk) disable iff (reset)
		(!ex_freeze && !id_freeze && sel_b == SEL_IMM) |=> operand_b == $past(simm));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ALU pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f alu_pipe_top.f --top-module alu_pipe_tb -o alu_pipe_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/alu_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1
